// File: source/icache_pkg.sv
// cache geometry constants, address field types, pc split helpers and miss handler states
package icache_pkg;

  ////////////////////////////////////////
  // geometry
  ////////////////////////////////////////
  localparam int PC_BITS          = 32;
  localparam int INST_BITS        = 32;
  localparam int INSTS_PER_LINE   = 4;
  localparam int LINE_BITS        = INSTS_PER_LINE * INST_BITS;
  localparam int FETCH_WIDTH      = 2;
  localparam int NUM_WAYS         = 4;
  localparam int NUM_SETS         = 16;
  localparam int BYTE_OFFSET_BITS = 2;
  localparam int OFFSET_BITS      = 2;
  localparam int INDEX_BITS       = 4;
  // whatever is left of the pc above index and offset
  localparam int TAG_BITS         = PC_BITS - INDEX_BITS - OFFSET_BITS - BYTE_OFFSET_BITS;

  ////////////////////////////////////////
  // field types
  ////////////////////////////////////////
  typedef logic [PC_BITS-1:0]              pc_t;
  typedef logic [TAG_BITS-1:0]             tag_t;
  typedef logic [INDEX_BITS-1:0]           index_t;
  typedef logic [OFFSET_BITS-1:0]          offset_t;
  typedef logic [$clog2(NUM_WAYS)-1:0]     way_t;
  typedef logic [INST_BITS-1:0]            inst_t;
  typedef logic [LINE_BITS-1:0]            line_t;
  // block address is {tag, index}
  typedef logic [TAG_BITS+INDEX_BITS-1:0]  block_addr_t;

  // single miss-status register, free or waiting on memory
  typedef enum logic {MSHR_IDLE, MSHR_BUSY} mshr_state_e;

  // pc layout: tag | index | offset | byte offset
  function automatic tag_t pc_tag(pc_t pc);
    return pc[PC_BITS-1 -: TAG_BITS];
  endfunction

  function automatic index_t pc_index(pc_t pc);
    return pc[BYTE_OFFSET_BITS+OFFSET_BITS +: INDEX_BITS];
  endfunction

  function automatic offset_t pc_offset(pc_t pc);
    return pc[BYTE_OFFSET_BITS +: OFFSET_BITS];
  endfunction

endpackage

// File: source/icache_fill_if.sv
// line fill interface from the miss handler into the tag and data arrays
interface icache_fill_if;
  import icache_pkg::*;

  // one-cycle strobe, arrays written at the end of that cycle
  logic   fill_valid;
  // way picked by the victim counter when the request went out
  way_t   fill_way;
  index_t fill_index;
  tag_t   fill_tag;
  line_t  fill_data;

  // miss handler side drives the fill
  modport miss_mp (
    output fill_valid, fill_way, fill_index, fill_tag, fill_data
  );

  // tag store side writes the arrays
  modport store_mp (
    input fill_valid, fill_way, fill_index, fill_tag, fill_data
  );

endinterface

// File: source/icache_tag_store.sv
// four-way tag, data and valid arrays with lookup, hit select, fill, invalidate and flush
module icache_tag_store (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 fetch_req_i,
  input  icache_pkg::pc_t      pc_i,
  input  logic                 inv_i,
  input  icache_pkg::index_t   inv_index_i,
  input  icache_pkg::way_t     inv_way_i,
  input  logic                 flush_i,
  icache_fill_if.store_mp      fill,
  output logic                 hit_o,
  output icache_pkg::line_t    hit_line_o,
  output icache_pkg::offset_t  offset_o,
  output logic                 flush_done_o
);
  import icache_pkg::*;

  // pc fields used for the lookup
  tag_t   lookup_tag;
  index_t lookup_index;

  // storage, indexed [way][set]
  tag_t                tag_q   [NUM_WAYS][NUM_SETS];
  line_t               data_q  [NUM_WAYS][NUM_SETS];
  logic [NUM_SETS-1:0] valid_q [NUM_WAYS];

  // per-way compare result
  logic [NUM_WAYS-1:0] way_hit;

  assign lookup_tag   = pc_tag(pc_i);
  assign lookup_index = pc_index(pc_i);
  assign offset_o     = pc_offset(pc_i);

  ////////////////////////////////////////
  // lookup
  ////////////////////////////////////////

  // read all ways of the indexed set and compare tags
  // no hit unless a fetch is requested
  always_comb
  begin
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      way_hit[w] = fetch_req_i & valid_q[w][lookup_index] &
                   (tag_q[w][lookup_index] == lookup_tag);
    end
  end

  assign hit_o = |way_hit;

  // pick the lowest hitting way, so one line at most reaches the aligner
  always_comb
  begin
    logic found;
    found      = 1'b0;
    hit_line_o = '0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      if (way_hit[w] && !found)
      begin
        found      = 1'b1;
        hit_line_o = data_q[w][lookup_index];
      end
    end
  end

  ////////////////////////////////////////
  // array updates
  ////////////////////////////////////////

  // fill writes tag and data into the way chosen at request time
  always_ff @(posedge clk)
  begin
    if (fill.fill_valid)
    begin
      tag_q[fill.fill_way][fill.fill_index]  <= fill.fill_tag;
      data_q[fill.fill_way][fill.fill_index] <= fill.fill_data;
    end
  end

  // valid bits: later statements win, so flush > invalidate > fill
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        valid_q[w] <= '0;
      end
    end
    else
    begin
      if (fill.fill_valid)
      begin
        valid_q[fill.fill_way][fill.fill_index] <= 1'b1;
      end
      if (inv_i)
      begin
        valid_q[inv_way_i][inv_index_i] <= 1'b0;
      end
      // flush drops every line in every way
      if (flush_i)
      begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
          valid_q[w] <= '0;
        end
      end
    end
  end

  // done one cycle after the flush, when all valid bits read clear
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      flush_done_o <= 1'b0;
    end
    else
    begin
      flush_done_o <= flush_i;
    end
  end

  // miss handler must never load a block that is already resident
  a_single_way_hit: assert property (@(posedge clk) disable iff (reset)
    hit_o |-> $onehot(way_hit));

endmodule

// File: source/icache_miss_handler.sv
// miss pulse, single miss-status register, round-robin victim counters, request and fill capture
module icache_miss_handler (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     fetch_req_i,
  input  icache_pkg::pc_t          pc_i,
  input  logic                     hit_i,
  input  logic                     mem_resp_valid_i,
  input  icache_pkg::tag_t         mem_resp_tag_i,
  input  icache_pkg::index_t       mem_resp_index_i,
  input  icache_pkg::line_t        mem_resp_data_i,
  output logic                     mem_req_valid_o,
  output icache_pkg::block_addr_t  mem_req_addr_o,
  output icache_pkg::way_t         mem_req_way_o,
  icache_fill_if.miss_mp           fill
);
  import icache_pkg::*;

  // miss detection
  logic   miss;
  logic   miss_d1;
  logic   miss_d2;
  logic   miss_pulse;
  pc_t    pc_q;
  tag_t   req_tag;
  index_t req_index;
  // the pending block is already being written this cycle
  logic   refill_same;

  // miss-status register
  mshr_state_e state_q;
  tag_t        mshr_tag_q;
  index_t      mshr_index_q;
  way_t        mshr_way_q;
  logic        resp_match;

  // one victim pointer per set
  way_t victim_q [NUM_SETS];

  ////////////////////////////////////////
  // miss pulse
  ////////////////////////////////////////
  assign miss = fetch_req_i & ~hit_i;

  // pc of the missing fetch, used one cycle later for the request
  always_ff @(posedge clk)
  begin
    pc_q <= pc_i;
  end

  // a fill breaks the episode so a still pending miss gets a fresh pulse
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      miss_d1 <= 1'b0;
      miss_d2 <= 1'b0;
    end
    else
    begin
      miss_d1 <= miss & ~fill.fill_valid;
      miss_d2 <= miss_d1 & ~fill.fill_valid;
    end
  end

  assign miss_pulse = miss_d1 & ~miss_d2;

  ////////////////////////////////////////
  // request
  ////////////////////////////////////////
  assign req_tag     = pc_tag(pc_q);
  assign req_index   = pc_index(pc_q);
  assign refill_same = fill.fill_valid & (fill.fill_tag == req_tag) &
                       (fill.fill_index == req_index);

  // one strobe per episode, only when the mshr is free or freeing now
  // no second copy of the block that is landing this cycle
  assign mem_req_valid_o = miss_pulse &
                           ((state_q == MSHR_IDLE) | (fill.fill_valid & ~refill_same));
  assign mem_req_addr_o  = {req_tag, req_index};
  assign mem_req_way_o   = victim_q[req_index];

  // victim pointer moves once per issued request
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < NUM_SETS; s++)
      begin
        victim_q[s] <= '0;
      end
    end
    else if (mem_req_valid_o)
    begin
      victim_q[req_index] <= victim_q[req_index] + 1'b1;
    end
  end

  ////////////////////////////////////////
  // mshr
  ////////////////////////////////////////

  // a new request outranks the fill that frees the entry
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state_q <= MSHR_IDLE;
    end
    else if (mem_req_valid_o)
    begin
      state_q <= MSHR_BUSY;
    end
    else if (fill.fill_valid)
    begin
      state_q <= MSHR_IDLE;
    end
  end

  always_ff @(posedge clk)
  begin
    if (mem_req_valid_o)
    begin
      mshr_tag_q   <= req_tag;
      mshr_index_q <= req_index;
      mshr_way_q   <= mem_req_way_o;
    end
  end

  // stray or stale responses are dropped
  assign resp_match = mem_resp_valid_i & (state_q == MSHR_BUSY) &
                      (mem_resp_tag_i == mshr_tag_q) & (mem_resp_index_i == mshr_index_q);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fill.fill_valid <= 1'b0;
    end
    else
    begin
      fill.fill_valid <= resp_match;
    end
  end

  // fill payload, meaningful only with fill_valid
  always_ff @(posedge clk)
  begin
    fill.fill_way   <= mshr_way_q;
    fill.fill_index <= mshr_index_q;
    fill.fill_tag   <= mshr_tag_q;
    fill.fill_data  <= mem_resp_data_i;
  end

  a_req_only_when_free: assert property (@(posedge clk) disable iff (reset)
    (mem_req_valid_o && state_q == MSHR_BUSY) |-> fill.fill_valid);

  a_fill_follows_resp: assert property (@(posedge clk) disable iff (reset)
    fill.fill_valid |-> $past(mem_resp_valid_i && state_q == MSHR_BUSY));

endmodule

// File: source/icache_fetch_align.sv
// instruction slot extraction from the hit line at the fetch offset
module icache_fetch_align (
  input  logic                 hit_i,
  input  icache_pkg::line_t    hit_line_i,
  input  icache_pkg::offset_t  offset_i,
  output icache_pkg::inst_t    inst_o [icache_pkg::FETCH_WIDTH],
  output logic [icache_pkg::FETCH_WIDTH-1:0] inst_valid_o
);
  import icache_pkg::*;

  // slot i takes word offset+i, nothing crosses into the next line
  always_comb
  begin
    int word;
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      word = int'(offset_i) + i;
      if (word < INSTS_PER_LINE)
      begin
        // word k sits at bits k*32 upward
        inst_o[i]       = hit_line_i[word*INST_BITS +: INST_BITS];
        inst_valid_o[i] = hit_i;
      end
      else
      begin
        // past the end of the line
        inst_o[i]       = '0;
        inst_valid_o[i] = 1'b0;
      end
    end
  end

endmodule

// File: source/icache_top.sv
// instruction cache top level connecting tag store, miss handler, fetch aligner and fill bus
module icache_top (
  input  logic                     clk,
  input  logic                     reset,

  // fetch side
  input  logic                     fetch_req_i,
  input  icache_pkg::pc_t          pc_i,
  output icache_pkg::inst_t        inst_o [icache_pkg::FETCH_WIDTH],
  output logic [icache_pkg::FETCH_WIDTH-1:0] inst_valid_o,

  // memory request, one strobe per miss
  output logic                     mem_req_valid_o,
  output icache_pkg::block_addr_t  mem_req_addr_o,
  output icache_pkg::way_t         mem_req_way_o,

  // memory response
  input  logic                     mem_resp_valid_i,
  input  icache_pkg::tag_t         mem_resp_tag_i,
  input  icache_pkg::index_t       mem_resp_index_i,
  input  icache_pkg::line_t        mem_resp_data_i,

  // maintenance
  input  logic                     inv_i,
  input  icache_pkg::index_t       inv_index_i,
  input  icache_pkg::way_t         inv_way_i,
  input  logic                     flush_i,
  output logic                     flush_done_o
);
  import icache_pkg::*;

  ////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////
  logic    hit;
  line_t   hit_line;
  offset_t offset;

  // line fill from miss handler to arrays
  icache_fill_if fill_if ();

  icache_tag_store tag_store_i (
    .clk          (clk),
    .reset        (reset),
    .fetch_req_i  (fetch_req_i),
    .pc_i         (pc_i),
    .inv_i        (inv_i),
    .inv_index_i  (inv_index_i),
    .inv_way_i    (inv_way_i),
    .flush_i      (flush_i),
    .fill         (fill_if.store_mp),
    .hit_o        (hit),
    .hit_line_o   (hit_line),
    .offset_o     (offset),
    .flush_done_o (flush_done_o)
  );

  icache_miss_handler miss_handler_i (
    .clk              (clk),
    .reset            (reset),
    .fetch_req_i      (fetch_req_i),
    .pc_i             (pc_i),
    .hit_i            (hit),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_tag_i   (mem_resp_tag_i),
    .mem_resp_index_i (mem_resp_index_i),
    .mem_resp_data_i  (mem_resp_data_i),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_req_way_o    (mem_req_way_o),
    .fill             (fill_if.miss_mp)
  );

  // same-cycle slot selection from the hit line
  icache_fetch_align fetch_align_i (
    .hit_i        (hit),
    .hit_line_i   (hit_line),
    .offset_i     (offset),
    .inst_o       (inst_o),
    .inst_valid_o (inst_valid_o)
  );

endmodule

// File: test/icache_tb.sv
// icache testbench with clock, reset, memory model, lcg, compare tasks, directed tests, timeout
module icache_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import icache_pkg::*;

  // run limit of several times the length of all tests
  localparam int     MAX_CYCLES = 2000;
  localparam tag_t   TAG_A      = 24'h123456;
  localparam index_t IDX_A      = 4'h3;
  localparam pc_t    PC_B       = 32'h0abcde94;
  localparam tag_t   TAG_C      = 24'h00c0de;
  localparam index_t IDX_C      = 4'h7;
  // one set shared by five tags for the replacement checks
  localparam index_t REPL_SET   = 4'h5;
  localparam tag_t   REPL_TAG0  = 24'h0001a0;

  logic                    clk;
  logic                    reset;
  logic                    fetch_req_i;
  pc_t                     pc_i;
  inst_t                   inst [FETCH_WIDTH];
  logic [FETCH_WIDTH-1:0]  inst_valid;
  logic                    mem_req_valid;
  block_addr_t             mem_req_addr;
  way_t                    mem_req_way;
  logic                    mem_resp_valid_i;
  tag_t                    mem_resp_tag_i;
  index_t                  mem_resp_index_i;
  line_t                   mem_resp_data_i;
  logic                    inv_i;
  index_t                  inv_index_i;
  way_t                    inv_way_i;
  logic                    flush_i;
  logic                    flush_done;

  logic [31:0] lcg_state = 32'hb4c6b45c;
  int          cycle_count = 0;
  // line sent for each block and the way it was requested into
  line_t       mem_map [block_addr_t];
  way_t        way_of [block_addr_t];
  way_t        victim_model [NUM_SETS];
  // every distinct block ever filled, in fill order
  block_addr_t filled_q [$];

  icache_top dut_i (
    .clk              (clk),
    .reset            (reset),
    .fetch_req_i      (fetch_req_i),
    .pc_i             (pc_i),
    .inst_o           (inst),
    .inst_valid_o     (inst_valid),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_addr_o   (mem_req_addr),
    .mem_req_way_o    (mem_req_way),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_tag_i   (mem_resp_tag_i),
    .mem_resp_index_i (mem_resp_index_i),
    .mem_resp_data_i  (mem_resp_data_i),
    .inv_i            (inv_i),
    .inv_index_i      (inv_index_i),
    .inv_way_i        (inv_way_i),
    .flush_i          (flush_i),
    .flush_done_o     (flush_done)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  initial
  begin
    while (cycle_count < MAX_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    abort_run($sformatf("Timeout: tests still running after %0d cycles", MAX_CYCLES));
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic line_t random_line();
    line_t data;
    for (int k = 0; k < INSTS_PER_LINE; k++)
    begin
      data[k*INST_BITS +: INST_BITS] = next_random();
    end
    return data;
  endfunction

  // pc is {tag, index, offset, 2'b00}
  function automatic pc_t make_pc(input tag_t tag, input index_t idx, input offset_t off);
    return {tag, idx, off, 2'b00};
  endfunction

  function automatic block_addr_t block_of(input pc_t pc);
    return pc[PC_BITS-1:OFFSET_BITS+BYTE_OFFSET_BITS];
  endfunction

  function automatic pc_t repl_pc(input int k);
    return make_pc(REPL_TAG0 + tag_t'(k), REPL_SET, '0);
  endfunction

  task automatic compare_inst(input string name, input inst_t act, input inst_t exp);
    if (act !== exp)
    begin
      abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  task automatic compare_valid(input string name, input logic [FETCH_WIDTH-1:0] act,
                               input logic [FETCH_WIDTH-1:0] exp);
    if (act !== exp)
    begin
      abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  task automatic compare_addr(input string name, input block_addr_t act, input block_addr_t exp);
    if (act !== exp)
    begin
      abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  task automatic compare_way(input string name, input way_t act, input way_t exp);
    if (act !== exp)
    begin
      abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  task automatic compare_bit(input string name, input logic act, input logic exp);
    if (act !== exp)
    begin
      abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  ////////////////////////////////////////
  // fetch and memory model tasks
  ////////////////////////////////////////

  // fetch misses and the request follows next cycle with the model's victim way
  task automatic miss_with_request(input pc_t pc);
    block_addr_t blk;
    index_t      idx;
    blk = block_of(pc);
    idx = blk[INDEX_BITS-1:0];
    @(posedge clk);
    fetch_req_i <= 1'b1;
    pc_i        <= pc;
    @(negedge clk);
    compare_valid("inst_valid_o", inst_valid, '0);
    @(posedge clk);
    fetch_req_i <= 1'b0;
    @(negedge clk);
    compare_bit("mem_req_valid_o", mem_req_valid, 1'b1);
    compare_addr("mem_req_addr_o", mem_req_addr, blk);
    compare_way("mem_req_way_o", mem_req_way, victim_model[idx]);
    way_of[blk]       = victim_model[idx];
    victim_model[idx] = victim_model[idx] + 2'd1;
  endtask

  // a miss while the mshr is taken gets no strobe
  task automatic busy_miss_no_request(input pc_t pc);
    @(posedge clk);
    fetch_req_i <= 1'b1;
    pc_i        <= pc;
    @(negedge clk);
    compare_valid("inst_valid_o", inst_valid, '0);
    @(posedge clk);
    fetch_req_i <= 1'b0;
    @(negedge clk);
    compare_bit("mem_req_valid_o", mem_req_valid, 1'b0);
  endtask

  // slot i holds word offset+i while it stays inside the line
  task automatic hit_with_data(input pc_t pc);
    block_addr_t            blk;
    line_t                  ref_line;
    inst_t                  exp_inst;
    logic [FETCH_WIDTH-1:0] exp_valid;
    int                     word;
    blk = block_of(pc);
    if (!mem_map.exists(blk))
    begin
      abort_run("no reference line recorded for a hit check");
    end
    ref_line = mem_map[blk];
    @(posedge clk);
    fetch_req_i <= 1'b1;
    pc_i        <= pc;
    @(negedge clk);
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      word = int'(pc[BYTE_OFFSET_BITS +: OFFSET_BITS]) + i;
      if (word < INSTS_PER_LINE)
      begin
        exp_valid[i] = 1'b1;
        exp_inst     = ref_line[word*INST_BITS +: INST_BITS];
      end
      else
      begin
        exp_valid[i] = 1'b0;
        exp_inst     = '0;
      end
      compare_inst($sformatf("inst_o[%0d]", i), inst[i], exp_inst);
    end
    compare_valid("inst_valid_o", inst_valid, exp_valid);
  endtask

  task automatic send_response(input tag_t tag, input index_t idx, input line_t data);
    @(posedge clk);
    mem_resp_valid_i <= 1'b1;
    mem_resp_tag_i   <= tag;
    mem_resp_index_i <= idx;
    mem_resp_data_i  <= data;
    @(posedge clk);
    mem_resp_valid_i <= 1'b0;
  endtask

  task automatic answer_request(input block_addr_t blk);
    line_t data;
    data = random_line();
    if (!mem_map.exists(blk))
    begin
      filled_q.push_back(blk);
    end
    mem_map[blk] = data;
    send_response(blk[TAG_BITS+INDEX_BITS-1:INDEX_BITS], blk[INDEX_BITS-1:0], data);
  endtask

  // response lands two cycles after the strobe
  task automatic serve_request(input block_addr_t blk);
    @(posedge clk);
    answer_request(blk);
  endtask

  task automatic miss_and_fill(input pc_t pc);
    miss_with_request(pc);
    serve_request(block_of(pc));
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic cold_miss();
    miss_with_request(make_pc(TAG_A, IDX_A, '0));
    busy_miss_no_request(PC_B);
    answer_request({TAG_A, IDX_A});
  endtask

  task automatic fill_then_hit();
    pc_t pc_c;
    pc_c = make_pc(TAG_C, IDX_C, '0);
    for (int off = 0; off < INSTS_PER_LINE; off++)
    begin
      hit_with_data(make_pc(TAG_A, IDX_A, offset_t'(off)));
    end
    // a response for another tag must not fill
    miss_with_request(pc_c);
    @(posedge clk);
    send_response(TAG_C ^ 24'h1, IDX_C, random_line());
    busy_miss_no_request(pc_c);
    serve_request(block_of(pc_c));
    hit_with_data(pc_c);
  endtask

  task automatic way_replacement();
    for (int k = 0; k < NUM_WAYS; k++)
    begin
      miss_and_fill(repl_pc(k));
    end
    for (int k = 0; k < NUM_WAYS; k++)
    begin
      hit_with_data(repl_pc(k));
    end
    // fifth tag wraps onto way 0
    miss_and_fill(repl_pc(4));
    for (int k = 1; k < NUM_WAYS; k++)
    begin
      hit_with_data(repl_pc(k));
    end
    miss_and_fill(repl_pc(0));
  endtask

  task automatic way_invalidate();
    @(posedge clk);
    fetch_req_i <= 1'b0;
    inv_i       <= 1'b1;
    inv_index_i <= REPL_SET;
    inv_way_i   <= way_of[block_of(repl_pc(4))];
    @(posedge clk);
    inv_i <= 1'b0;
    hit_with_data(repl_pc(0));
    hit_with_data(repl_pc(2));
    hit_with_data(repl_pc(3));
    // other set keeps its line in the same way
    hit_with_data(make_pc(TAG_A, IDX_A, '0));
    miss_and_fill(repl_pc(4));
    hit_with_data(repl_pc(4));
  endtask

  task automatic full_flush();
    int n;
    n = filled_q.size();
    @(posedge clk);
    fetch_req_i <= 1'b0;
    flush_i     <= 1'b1;
    @(negedge clk);
    compare_bit("flush_done_o", flush_done, 1'b0);
    @(posedge clk);
    flush_i <= 1'b0;
    @(negedge clk);
    compare_bit("flush_done_o", flush_done, 1'b1);
    @(negedge clk);
    compare_bit("flush_done_o", flush_done, 1'b0);
    // every line filled so far is gone
    // the first refill keeps the mshr busy while the rest are probed
    miss_with_request({filled_q[0], 4'h0});
    for (int i = 1; i < n; i++)
    begin
      busy_miss_no_request({filled_q[i], 4'h0});
    end
    answer_request(filled_q[0]);
    hit_with_data({filled_q[0], 4'h0});
  endtask

  initial
  begin
    reset            <= 1'b1;
    fetch_req_i      <= 1'b0;
    pc_i             <= '0;
    mem_resp_valid_i <= 1'b0;
    mem_resp_tag_i   <= '0;
    mem_resp_index_i <= '0;
    mem_resp_data_i  <= '0;
    inv_i            <= 1'b0;
    inv_index_i      <= '0;
    inv_way_i        <= '0;
    flush_i          <= 1'b0;
    for (int s = 0; s < NUM_SETS; s++)
    begin
      victim_model[s] = '0;
    end
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    cold_miss();
    fill_then_hit();
    way_replacement();
    way_invalidate();
    full_flush();
    @(posedge clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: vlog.f
source/icache_pkg.sv
source/icache_fill_if.sv
source/icache_tag_store.sv
source/icache_miss_handler.sv
source/icache_fetch_align.sv
source/icache_top.sv
test/icache_tb.sv

// File: run.sh
#!/bin/bash
# build the icache testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module icache_tb -f vlog.f
./obj_dir/Vicache_tb | tee sim.log
if grep -qF '*** PASSED ***' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
